// File: buf_macros.svh
`ifndef BUF_MACROS_SVH
`define BUF_MACROS_SVH

// write port and host data width
`define W_DATA_W 32

// read port width, one byte
`define R_DATA_W 8

// byte address into the buffer, 256 bytes
`define BYTE_ADDR_W 8

// word address on the wide side
`define WORD_ADDR_W (`BYTE_ADDR_W - $clog2(`W_DATA_W / `R_DATA_W))

// width helpers for the asymmetric ram
`define max(a, b) (((a) > (b)) ? (a) : (b))
`define min(a, b) (((a) < (b)) ? (a) : (b))

`endif

// File: cmd_pkg.sv
`include "buf_macros.svh"

package cmd_pkg;

   // host command opcodes
   typedef enum logic [1:0] {
      CMD_NOP   = 2'd0,
      CMD_LOAD  = 2'd1,
      CMD_START = 2'd2,
      CMD_CLEAR = 2'd3
   } cmd_op_t;

   // start command fields, count above addr
   typedef struct packed {
      logic [`BYTE_ADDR_W-1:0] count;
      logic [`BYTE_ADDR_W-1:0] addr;
   } start_args_t;

endpackage

// File: rd_pkg.sv
`include "buf_macros.svh"

package rd_pkg;

   // byte reader states
   typedef enum logic [1:0] {
      RD_IDLE  = 2'd0,
      RD_RUN   = 2'd1,
      RD_DRAIN = 2'd2
   } rd_state_t;

   // one byte of the output stream
   typedef logic [`R_DATA_W-1:0] byte_t;

endpackage

// File: ram_t2p.sv
module ram_t2p #(
   parameter int DATA_W = 8,
   parameter int ADDR_W = 6
) (
   input  logic              r_clk,
   // write port
   input  logic              w_en,
   input  logic [ADDR_W-1:0] w_addr,
   input  logic [DATA_W-1:0] w_data,
   // read port
   input  logic              r_en,
   input  logic [ADDR_W-1:0] r_addr,
   output logic [DATA_W-1:0] r_data
);

   localparam int DEPTH = 2 ** ADDR_W;

   logic [DATA_W-1:0] mem [DEPTH];

   // synchronous write
   always_ff @(posedge r_clk) begin
      if (w_en) begin
         mem[w_addr] <= w_data;
      end
   end

   // registered read, old data on a same-address collision
   always_ff @(posedge r_clk) begin
      if (r_en) begin
         r_data <= mem[r_addr];
      end
   end

endmodule

// File: ram_t2p_asym.sv
`include "buf_macros.svh"

module ram_t2p_asym #(
   parameter int W_DATA_W  = 32,
   parameter int R_DATA_W  = 8,
   parameter int ADDR_W    = 8,
   // derived widths, ADDR_W is the narrow side address
   parameter int MAXDATA_W = `max(W_DATA_W, R_DATA_W),
   parameter int MINDATA_W = `min(W_DATA_W, R_DATA_W),
   parameter int MINADDR_W = ADDR_W - $clog2(MAXDATA_W / MINDATA_W),
   parameter int W_ADDR_W  = (W_DATA_W == MAXDATA_W) ? MINADDR_W : ADDR_W,
   parameter int R_ADDR_W  = (R_DATA_W == MAXDATA_W) ? MINADDR_W : ADDR_W
) (
   input  logic                r_clk,
   // write port
   input  logic                w_en,
   input  logic [W_DATA_W-1:0] w_data,
   input  logic [W_ADDR_W-1:0] w_addr,
   // read port
   input  logic                r_en,
   input  logic [R_ADDR_W-1:0] r_addr,
   output logic [R_DATA_W-1:0] r_data
);

   // one block per narrow lane
   localparam int N = MAXDATA_W / MINDATA_W;

   logic [N-1:0]         en_wr;
   logic [MINDATA_W-1:0] data_wr [N];
   logic [MINADDR_W-1:0] addr_wr [N];
   logic [MINDATA_W-1:0] data_rd [N];
   logic [MINADDR_W-1:0] addr_rd [N];

   genvar i;
   generate
      for (i = 0; i < N; i++) begin : g_blk
         ram_t2p #(
            .DATA_W(MINDATA_W),
            .ADDR_W(MINADDR_W)
         ) u_ram (
            .r_clk (r_clk),
            .w_en  (en_wr[i]),
            .w_addr(addr_wr[i]),
            .w_data(data_wr[i]),
            .r_en  (r_en),
            .r_addr(addr_rd[i]),
            .r_data(data_rd[i])
         );
      end

      if (W_DATA_W > R_DATA_W) begin : g_wide_wr
         // lane of the pending read, captured with the read itself
         logic [R_ADDR_W-W_ADDR_W-1:0] lane_q;

         // all lanes written together, lane 0 in the low bits
         always_comb begin
            for (int j = 0; j < N; j++) begin
               en_wr[j]   = w_en;
               data_wr[j] = w_data[j*MINDATA_W +: MINDATA_W];
               addr_wr[j] = w_addr;
               addr_rd[j] = r_addr[R_ADDR_W-1 -: W_ADDR_W];
            end
         end

         always_ff @(posedge r_clk) begin
            if (r_en) begin
               lane_q <= r_addr[R_ADDR_W-W_ADDR_W-1:0];
            end
         end

         assign r_data = data_rd[lane_q];

      end else if (W_DATA_W < R_DATA_W) begin : g_narrow_wr
         // one block per write, picked by the low address bits
         always_comb begin
            for (int j = 0; j < N; j++) begin
               en_wr[j]   = w_en &&
                            (w_addr[W_ADDR_W-R_ADDR_W-1:0] == (W_ADDR_W-R_ADDR_W)'(j));
               data_wr[j] = w_data;
               addr_wr[j] = w_addr[W_ADDR_W-1 -: R_ADDR_W];
            end
         end

         // whole word comes back from all blocks at once
         always_comb begin
            for (int k = 0; k < N; k++) begin
               addr_rd[k] = r_addr;
               r_data[k*MINDATA_W +: MINDATA_W] = data_rd[k];
            end
         end

      end else begin : g_equal
         assign en_wr[0]   = w_en;
         assign data_wr[0] = w_data;
         assign addr_wr[0] = w_addr;
         assign addr_rd[0] = r_addr;
         assign r_data     = data_rd[0];
      end
   endgenerate

   // reader must present a clean address with every read
   a_raddr_known: assert property (@(posedge r_clk) r_en |-> !$isunknown(r_addr))
      else $error("ram_t2p_asym: read with unknown address");

endmodule

// File: cmd_regs.sv
`include "buf_macros.svh"

module cmd_regs (
   input  logic                    r_clk,
   input  logic                    reset,
   input  logic                    cmd_valid,
   input  cmd_pkg::cmd_op_t        cmd_op,
   input  logic [`W_DATA_W-1:0]    cmd_data,
   input  logic                    busy,
   output logic                    w_en,
   output logic [`WORD_ADDR_W-1:0] w_addr,
   output logic [`W_DATA_W-1:0]    w_data,
   output logic                    rd_start,
   output logic [`BYTE_ADDR_W-1:0] rd_addr,
   output logic [`BYTE_ADDR_W-1:0] rd_count
);

   import cmd_pkg::*;

   start_args_t             start_args;
   logic                    load_hit;
   logic                    clear_hit;
   logic                    start_hit;
   logic                    start_ok;
   logic [`WORD_ADDR_W-1:0] wr_ptr;

   // opcode decode, qualified by the strobe
   always_comb begin
      load_hit  = 1'b0;
      clear_hit = 1'b0;
      start_hit = 1'b0;
      if (cmd_valid) begin
         case (cmd_op)
            CMD_LOAD:  load_hit  = 1'b1;
            CMD_CLEAR: clear_hit = 1'b1;
            CMD_START: start_hit = 1'b1;
            default:   ;
         endcase
      end
   end

   assign start_args = start_args_t'(cmd_data[2*`BYTE_ADDR_W-1:0]);

   // drop starts while a run is pending or active, and empty runs
   assign start_ok = start_hit && !busy && !rd_start && (start_args.count != '0);

   // load goes straight to the ram at the current pointer
   assign w_en   = load_hit;
   assign w_addr = wr_ptr;
   assign w_data = cmd_data;

   // word pointer wraps on its own width
   always_ff @(posedge r_clk) begin
      if (reset) begin
         wr_ptr <= '0;
      end else if (clear_hit) begin
         wr_ptr <= '0;
      end else if (load_hit) begin
         wr_ptr <= wr_ptr + 1'b1;
      end
   end

   always_ff @(posedge r_clk) begin
      if (reset) begin
         rd_start <= 1'b0;
      end else begin
         rd_start <= start_ok;
      end
   end

   // run settings, held until the next accepted start
   always_ff @(posedge r_clk) begin
      if (start_ok) begin
         rd_addr  <= start_args.addr;
         rd_count <= start_args.count;
      end
   end

   a_start_pulse: assert property (@(posedge r_clk) disable iff (reset)
      rd_start |=> !rd_start)
      else $error("cmd_regs: rd_start held for more than one cycle");

endmodule

// File: byte_reader.sv
`include "buf_macros.svh"

module byte_reader (
   input  logic                    r_clk,
   input  logic                    reset,
   input  logic                    rd_start,
   input  logic [`BYTE_ADDR_W-1:0] rd_addr,
   input  logic [`BYTE_ADDR_W-1:0] rd_count,
   output logic                    r_en,
   output logic [`BYTE_ADDR_W-1:0] r_addr,
   input  rd_pkg::byte_t           r_data,
   output logic                    out_valid,
   output rd_pkg::byte_t           out_byte,
   output logic                    out_last,
   output logic                    busy
);

   import rd_pkg::*;

   rd_state_t               state;
   rd_state_t               state_nxt;
   logic [`BYTE_ADDR_W-1:0] addr_q;
   logic [`BYTE_ADDR_W-1:0] remain_q;
   logic                    valid_q;

   always_comb begin
      state_nxt = state;
      case (state)
         RD_IDLE:  if (rd_start) state_nxt = RD_RUN;
         // last read goes out this cycle
         RD_RUN:   if (remain_q == 1) state_nxt = RD_DRAIN;
         RD_DRAIN: state_nxt = RD_IDLE;
         default:  state_nxt = RD_IDLE;
      endcase
   end

   always_ff @(posedge r_clk) begin
      if (reset) begin
         state    <= RD_IDLE;
         remain_q <= '0;
         valid_q  <= 1'b0;
      end else begin
         state   <= state_nxt;
         valid_q <= r_en;
         if (rd_start) begin
            remain_q <= rd_count;
         end else if (r_en) begin
            remain_q <= remain_q - 1'b1;
         end
      end
   end

   // byte address, wraps at the top of the buffer
   always_ff @(posedge r_clk) begin
      if (rd_start) begin
         addr_q <= rd_addr;
      end else if (r_en) begin
         addr_q <= addr_q + 1'b1;
      end
   end

   // one read per cycle in RD_RUN, its byte shows up a cycle later
   assign r_en      = (state == RD_RUN);
   assign r_addr    = addr_q;
   assign out_valid = valid_q;
   assign out_byte  = r_data;
   assign out_last  = (state == RD_DRAIN);
   assign busy      = (state != RD_IDLE);

   a_valid_busy: assert property (@(posedge r_clk) disable iff (reset)
      out_valid |-> busy)
      else $error("byte_reader: out_valid outside a run");

   a_start_idle: assert property (@(posedge r_clk) disable iff (reset)
      rd_start |-> (state == RD_IDLE))
      else $error("byte_reader: rd_start during a run");

endmodule

// File: unpack_buffer_top.sv
`include "buf_macros.svh"

module unpack_buffer_top (
   input  logic                 r_clk,
   input  logic                 reset,
   input  logic                 cmd_valid,
   input  cmd_pkg::cmd_op_t     cmd_op,
   input  logic [`W_DATA_W-1:0] cmd_data,
   output logic                 out_valid,
   output rd_pkg::byte_t        out_byte,
   output logic                 out_last,
   output logic                 busy
);

   import rd_pkg::*;

   logic                    w_en;
   logic [`WORD_ADDR_W-1:0] w_addr;
   logic [`W_DATA_W-1:0]    w_data;
   logic                    rd_start;
   logic [`BYTE_ADDR_W-1:0] rd_addr;
   logic [`BYTE_ADDR_W-1:0] rd_count;
   logic                    r_en;
   logic [`BYTE_ADDR_W-1:0] r_addr;
   byte_t                   r_data;

   cmd_regs u_cmd_regs (
      .r_clk    (r_clk),
      .reset    (reset),
      .cmd_valid(cmd_valid),
      .cmd_op   (cmd_op),
      .cmd_data (cmd_data),
      .busy     (busy),
      .w_en     (w_en),
      .w_addr   (w_addr),
      .w_data   (w_data),
      .rd_start (rd_start),
      .rd_addr  (rd_addr),
      .rd_count (rd_count)
   );

   byte_reader u_byte_reader (
      .r_clk    (r_clk),
      .reset    (reset),
      .rd_start (rd_start),
      .rd_addr  (rd_addr),
      .rd_count (rd_count),
      .r_en     (r_en),
      .r_addr   (r_addr),
      .r_data   (r_data),
      .out_valid(out_valid),
      .out_byte (out_byte),
      .out_last (out_last),
      .busy     (busy)
   );

   // wide write, byte read
   ram_t2p_asym #(
      .W_DATA_W(`W_DATA_W),
      .R_DATA_W(`R_DATA_W),
      .ADDR_W  (`BYTE_ADDR_W)
   ) u_ram (
      .r_clk (r_clk),
      .w_en  (w_en),
      .w_data(w_data),
      .w_addr(w_addr),
      .r_en  (r_en),
      .r_addr(r_addr),
      .r_data(r_data)
   );

endmodule

// File: unpack_buffer_tb.sv
`include "buf_macros.svh"

module unpack_buffer_tb;

   import cmd_pkg::*;
   import rd_pkg::*;

   localparam int PERIOD = 100;
   localparam int MARGIN = 20;
   // lfsr bits added to each command gap
   localparam int GAP_BITS = 2;

   logic                 r_clk;
   logic                 reset;
   logic                 cmd_valid;
   cmd_op_t              cmd_op;
   logic [`W_DATA_W-1:0] cmd_data;
   logic                 out_valid;
   byte_t                out_byte;
   logic                 out_last;
   logic                 busy;

   // reference copy of the buffer, one entry per word
   logic [`W_DATA_W-1:0] ref_mem [64];
   logic [5:0]           ref_ptr;
   logic [7:0]           lfsr_state;
   int                   cyc;
   int                   budget;
   int                   free_c;
   int                   busy_from;
   int                   busy_to;
   int                   n_exp;
   int                   n_seen;
   byte_t                exp_byte_q [$];
   bit                   exp_last_q [$];
   int                   exp_cyc_q [$];

   unpack_buffer_top u_unpack_buffer_top (
      .r_clk    (r_clk),
      .reset    (reset),
      .cmd_valid(cmd_valid),
      .cmd_op   (cmd_op),
      .cmd_data (cmd_data),
      .out_valid(out_valid),
      .out_byte (out_byte),
      .out_last (out_last),
      .busy     (busy)
   );

   always #(PERIOD / 2) r_clk = ~r_clk;

   always @(posedge r_clk) begin
      cyc <= cyc + 1;
   end

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("=== FAIL ===");
      $fatal(1);
   endtask

   task automatic check_byte(input string name, input byte_t got, input byte_t exp);
      if (got !== exp) begin
         abort_run($sformatf("Fail %s: expected 0x%02h, got 0x%02h", name, exp, got));
      end
   endtask

   task automatic check_flag(input string name, input logic got, input bit exp);
      if (got !== exp) begin
         abort_run($sformatf("Fail %s: expected 0x%0h, got 0x%0h", name, exp, got));
      end
   endtask

   // x^8 + x^6 + x^5 + x^4 + 1
   function automatic logic [7:0] lfsr_next(input logic [7:0] s);
      return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
   endfunction

   task automatic take_gap(output int extra);
      extra = 0;
      for (int i = 0; i < GAP_BITS; i++) begin
         lfsr_state = lfsr_next(lfsr_state);
         extra = (extra << 1) | int'(lfsr_state[0]);
      end
   endtask

   // each byte holds the inverse of its own byte address
   function automatic logic [`W_DATA_W-1:0] fill_word(input logic [5:0] w);
      return ~{w, 2'd3, w, 2'd2, w, 2'd1, w, 2'd0};
   endfunction

   // byte b sits in word b/4, lane b mod 4, lane 0 in the low bits
   function automatic byte_t ref_byte(input logic [7:0] b);
      logic [`W_DATA_W-1:0] w;
      w = ref_mem[b[7:2]];
      return byte_t'(w >> {b[1:0], 3'b000});
   endfunction

   task automatic drive_cmd(input cmd_op_t op, input logic [`W_DATA_W-1:0] data);
      cmd_valid = 1'b1;
      cmd_op    = op;
      cmd_data  = data;
      @(negedge r_clk);
      cmd_valid = 1'b0;
      cmd_op    = CMD_NOP;
      cmd_data  = '0;
   endtask

   task automatic wait_idle();
      while (exp_cyc_q.size() != 0 || busy !== 1'b0) begin
         @(negedge r_clk);
      end
   endtask

   // start strobe driven at cycle c, expected bytes follow in the golden file
   task automatic run_start(input int fd, input logic [`W_DATA_W-1:0] data, input int c);
      logic [7:0] addr;
      logic [7:0] b;
      int         cnt;
      int         code;
      int         glast;
      byte_t      gbyte;
      addr = data[7:0];
      cnt  = int'(data[15:8]);
      // dropped when empty or while the previous run is still pending
      if (cnt != 0 && c >= free_c) begin
         free_c    = c + cnt + 3;
         busy_from = c + 2;
         busy_to   = c + cnt + 2;
         budget    += cnt + 4;
         n_exp     += cnt;
         for (int i = 0; i < cnt; i++) begin
            code = $fscanf(fd, "%h %d\n", gbyte, glast);
            if (code != 2) begin
               abort_run("golden file ends in the middle of a run");
            end
            b = addr + 8'(i);
            check_byte("golden byte", gbyte, ref_byte(b));
            check_flag("golden last", glast != 0, i == cnt - 1);
            exp_byte_q.push_back(gbyte);
            exp_last_q.push_back(glast != 0);
            exp_cyc_q.push_back(c + 3 + i);
         end
      end
   endtask

   always @(negedge r_clk) begin : monitor
      bit exp_valid;
      if (cyc >= 2) begin
         exp_valid = (exp_cyc_q.size() != 0) && (exp_cyc_q[0] == cyc);
         check_flag("out_valid", out_valid, exp_valid);
         check_flag("busy", busy, (cyc >= busy_from) && (cyc <= busy_to));
         if (exp_valid) begin
            check_byte("out_byte", out_byte, exp_byte_q.pop_front());
            check_flag("out_last", out_last, exp_last_q.pop_front());
            void'(exp_cyc_q.pop_front());
            n_seen++;
         end else begin
            check_flag("out_last", out_last, 1'b0);
         end
      end
   end

   always @(posedge r_clk) begin : watchdog
      if (cyc > budget) begin
         abort_run("watchdog expired before the run finished");
      end
   end

   initial begin
      int                   fd;
      int                   code;
      int                   gap;
      int                   op_num;
      int                   extra;
      int                   c;
      bit                   more;
      cmd_op_t              op;
      logic [`W_DATA_W-1:0] data;
      r_clk      = 1'b0;
      reset      = 1'b1;
      cmd_valid  = 1'b0;
      cmd_op     = CMD_NOP;
      cmd_data   = '0;
      cyc        = 0;
      budget     = MARGIN + 2 + 66;
      free_c     = 0;
      busy_from  = 1;
      busy_to    = 0;
      n_exp      = 0;
      n_seen     = 0;
      lfsr_state = 8'd25;
      ref_ptr    = '0;
      fd = $fopen("unpack_buffer_golden.txt", "r");
      if (fd == 0) begin
         abort_run("cannot open unpack_buffer_golden.txt");
      end
      repeat (2) @(posedge r_clk);
      @(negedge r_clk);
      reset = 1'b0;

      // background over all 64 words, pointer wraps back to 0
      drive_cmd(CMD_CLEAR, '0);
      for (int w = 0; w < 64; w++) begin
         ref_mem[ref_ptr] = fill_word(ref_ptr);
         drive_cmd(CMD_LOAD, fill_word(ref_ptr));
         ref_ptr = ref_ptr + 6'd1;
      end

      more = 1'b1;
      while (more) begin
         code = $fscanf(fd, "%d %d %h\n", gap, op_num, data);
         if (code != 3) begin
            more = 1'b0;
         end else begin
            op = cmd_op_t'(op_num[1:0]);
            take_gap(extra);
            budget += gap + extra + 2;
            // buffer contents stay fixed while a run is in flight
            if (op != CMD_START) begin
               wait_idle();
            end
            repeat (gap + extra) @(negedge r_clk);
            c = cyc;
            case (op)
               CMD_LOAD: begin
                  ref_mem[ref_ptr] = data;
                  ref_ptr = ref_ptr + 6'd1;
               end
               CMD_CLEAR: ref_ptr = '0;
               CMD_START: run_start(fd, data, c);
               default:   ;
            endcase
            drive_cmd(op, data);
         end
      end
      $fclose(fd);

      budget += 12;
      wait_idle();
      repeat (8) @(negedge r_clk);
      if (n_exp > 0 && n_seen == n_exp) begin
         $display("=== PASS ===");
         $finish;
      end else begin
         abort_run($sformatf("expected %0d bytes in total but saw %0d", n_exp, n_seen));
      end
   end

endmodule

// File: unpack_buffer_golden.txt
2 1 44332211
0 1 88776655
1 2 00000500
11 0
22 0
33 0
44 0
55 1
0 2 00000300
3 2 00000002
2 3 00000000
0 1 DDCCBBAA
12 2 00000603
DD 0
55 0
66 0
77 0
88 0
F7 1
10 2 000004FE
01 0
00 0
AA 0
BB 1
4 1 0F0E0D0C
2 2 00000104
0C 1
5 2 00000207
0F 0
F7 1
6 2 00000110
EF 1

// File: src.f
+incdir+.
cmd_pkg.sv
rd_pkg.sv
ram_t2p.sv
ram_t2p_asym.sv
cmd_regs.sv
byte_reader.sv
unpack_buffer_top.sv
unpack_buffer_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator and run it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module unpack_buffer_tb -f src.f -o unpack_buffer_sim

./obj_dir/unpack_buffer_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "=== FAIL ===" sim.log; then
   echo "simulation failed"
   exit 1
fi
grep -q "=== PASS ===" sim.log
